//--- regFetchTop.f
+incdir+verilog
+incdir+test
verilog/regFetchPkg.sv
verilog/dualPortRam.sv
verilog/registerFile.sv
verilog/creditFifo.sv
verilog/opDispatcher.sv
verilog/regLane.sv
verilog/respCollector.sv
verilog/regFetchTop.sv
test/regFetchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the register fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module regFetchTb \
	-f regFetchTop.f \
	--Mdir obj_dir -o simRegFetch

./obj_dir/simRegFetch

//--- test/regFetchModel.svh
// Reference model of the lane register files
// Applies ops in send order, reads taken before the op's own write
// Keeps the expected responses per lane in arrival order
`ifndef REGFETCH_MODEL_SVH
`define REGFETCH_MODEL_SVH

logic [`DATA_WIDTH-1:0] modelRegs [`NUM_LANES][2**`ADDR_WIDTH];  // Last value written
regRespT                expQ [`NUM_LANES][$];  // Responses still owed, per lane

// Register 0 always reads zero
function automatic logic [`DATA_WIDTH-1:0] modelRead(
	input laneIdxT                lane,
	input logic [`ADDR_WIDTH-1:0] addr
);
	if (addr == '0)
		return '0;
	return modelRegs[lane][addr];
endfunction

// Called once per op as it is driven upstream
task automatic modelApply(input regOpT op);
	regRespT want;
	want.tag     = op.tag;
	want.lane    = op.lane;
	want.rs0Data = modelRead(op.lane, op.rs0);  // Old values first
	want.rs1Data = modelRead(op.lane, op.rs1);
	if (op.rdWrEn && op.rd != '0)
		modelRegs[op.lane][op.rd] = op.rdData;  // r0 writes dropped
	expQ[op.lane].push_back(want);
endtask

// Responses not yet seen on the output
function automatic int pendingCount();
	int total;
	total = 0;
	for (int i = 0; i < `NUM_LANES; i++)
		total += expQ[i].size();
	return total;
endfunction

`endif

//--- test/regFetchTb.sv
// Register fetch testbench
// Random ops from an LCG through the credited upstream port
// Downstream credits returned at random, responses checked per lane
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module regFetchTb;

	import regFetchPkg::*;

	localparam int AW          = `ADDR_WIDTH;
	localparam int DW          = `DATA_WIDTH;
	localparam int NUM_REGS    = 2**AW;
	localparam int RANDOM_OPS  = 300;
	localparam int CREDIT_WAIT = 2000;  // Cycles allowed for one upstream credit
	localparam int DRAIN_WAIT  = 5000;

	logic    iClkX2    = 1'b0;
	logic    rstN;
	logic    opValid;
	regOpT   opIn;
	logic    outCredit = 1'b0;
	logic    opCredit;
	logic    outValid;
	regRespT outResp;

	logic [31:0]           stimSeed    = 32'd42;  // Ops
	logic [31:0]           creditSeed  = 32'd42;  // Downstream credit returns
	logic [`TAG_WIDTH-1:0] tagNext     = '0;
	int                    sent        = 0;  // Ops driven upstream
	int                    creditsBack = 0;  // opCredit pulses seen
	int                    owed        = 0;  // Responses not yet credited back

	`include "regFetchModel.svh"

	regFetchTop i_dut (
		.iClkX2   (iClkX2),
		.rstN     (rstN),
		.opValid  (opValid),
		.opIn     (opIn),
		.outCredit(outCredit),
		.opCredit (opCredit),
		.outValid (outValid),
		.outResp  (outResp)
	);

	initial begin
		forever #4 iClkX2 = ~iClkX2;  // 8 ns period
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// All four response fields against the model
	task automatic checkResp(input regRespT got, input regRespT want);
		logic bad;
		bad = 1'b0;
		if (got.tag !== want.tag) begin
			$display("error: outResp.tag got %h expected %h", got.tag, want.tag);
			bad = 1'b1;
		end
		if (got.lane !== want.lane) begin
			$display("error: outResp.lane got %h expected %h", got.lane, want.lane);
			bad = 1'b1;
		end
		if (got.rs0Data !== want.rs0Data) begin
			$display("error: outResp.rs0Data got %h expected %h", got.rs0Data, want.rs0Data);
			bad = 1'b1;
		end
		if (got.rs1Data !== want.rs1Data) begin
			$display("error: outResp.rs1Data got %h expected %h", got.rs1Data, want.rs1Data);
			bad = 1'b1;
		end
		if (bad)
			abortRun("response does not match the reference model");
	endtask

	task automatic checkCredits(input string name, input int count, input int limit);
		if (count > limit)
			abortRun($sformatf("%s credit count %0d went over its limit of %0d",
				name, count, limit));
	endtask

	task automatic checkLow(input string name, input logic got);
		if (got !== 1'b0)
			abortRun($sformatf("error: %s got %h expected %h", name, got, 1'b0));
	endtask

	function automatic logic [31:0] lcgNext(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	// Builds an op and hands out the next tag
	function automatic regOpT makeOp(
		input laneIdxT       lane,
		input logic [AW-1:0] rs0,
		input logic [AW-1:0] rs1,
		input logic          wrEn,
		input logic [AW-1:0] rd,
		input logic [DW-1:0] data
	);
		regOpT op;
		op.tag    = tagNext;
		op.lane   = lane;
		op.rs0    = rs0;
		op.rs1    = rs1;
		op.rdWrEn = wrEn;
		op.rd     = rd;
		op.rdData = data;
		tagNext   = tagNext + 1'b1;
		return op;
	endfunction

	// Upper LCG bits only since the low ones repeat quickly
	function automatic regOpT randomOp();
		logic [31:0]   r;
		logic [31:0]   a;
		logic [31:0]   d;
		logic [AW-1:0] rs0;
		logic [AW-1:0] rd;
		r   = lcgNext(stimSeed);
		a   = lcgNext(stimSeed);
		d   = lcgNext(stimSeed);
		rs0 = AW'(a >> 27);
		rd  = (r[26:24] == 3'd0) ? rs0 : AW'(a >> 17);  // Same register now and then
		return makeOp(laneIdxT'(r >> 28), rs0, AW'(a >> 22), r[27], rd, DW'(d));
	endfunction

	// Drives one op as soon as upstream holds a credit
	task automatic sendOp(input regOpT op);
		int waitCycles;
		waitCycles = 0;
		@(posedge iClkX2);
		while (`IN_DEPTH + creditsBack - sent <= 0) begin
			opValid <= 1'b0;
			waitCycles++;
			if (waitCycles > CREDIT_WAIT)
				abortRun("no upstream credit came back in time");
			@(posedge iClkX2);
		end
		opValid <= 1'b1;
		opIn    <= op;
		sent    <= sent + 1;
		modelApply(op);
	endtask

	task automatic idleCycle();
		@(posedge iClkX2);
		opValid <= 1'b0;
	endtask

	// Lane whose oldest owed response carries this tag or -1
	function automatic int findLaneByTag(input logic [`TAG_WIDTH-1:0] tag);
		int hit;
		hit = -1;
		for (int l = 0; l < `NUM_LANES; l++) begin
			if (expQ[l].size() != 0 && expQ[l][0].tag == tag)
				hit = l;
		end
		return hit;
	endfunction

	// Credit accounting, output checks and downstream credit returns
	always @(posedge iClkX2) begin
		regRespT     want;
		logic [31:0] r;
		int          hitLane;
		if (!rstN) begin
			outCredit <= 1'b0;
		end else begin
			if (opCredit)
				creditsBack <= creditsBack + 1;
			checkCredits("upstream", `IN_DEPTH + creditsBack + int'(opCredit) - sent,
				`IN_DEPTH);
			if (outValid) begin
				hitLane = findLaneByTag(outResp.tag);  // Matched by tag, lane compared below
				if (hitLane < 0)
					abortRun($sformatf("unexpected response with tag %h on lane %0d",
						outResp.tag, outResp.lane));
				want = expQ[hitLane].pop_front();
				checkResp(outResp, want);
				owed++;
			end
			checkCredits("downstream", owed, `OUT_CREDITS);
			r = lcgNext(creditSeed);
			if (owed > 0 && r[31:29] < 3'd3) begin  // Withheld most cycles
				outCredit <= 1'b1;
				owed--;
			end else begin
				outCredit <= 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] d;
		laneIdxT     lane;
		int          waitCycles;
		rstN    = 1'b0;
		opValid = 1'b0;
		opIn    = '0;
		repeat (16) @(posedge iClkX2);
		rstN <= 1'b1;

		// Quiet until the first op
		repeat (8) begin
			@(posedge iClkX2);
			checkLow("opCredit", opCredit);
			checkLow("outValid", outValid);
		end

		// Fill every register while reading only r0 or the one written before
		for (int l = 0; l < `NUM_LANES; l++) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				d = lcgNext(stimSeed);
				sendOp(makeOp(laneIdxT'(l), '0, AW'((r == 0) ? 0 : r - 1), 1'b1,
					AW'(r), DW'(d)));
			end
		end

		// r0 write, then read and write of r7 in one op, then read back
		for (int l = 0; l < `NUM_LANES; l++) begin
			lane = laneIdxT'(l);
			d    = lcgNext(stimSeed);
			sendOp(makeOp(lane, '0, '0, 1'b1, '0, DW'(d)));
			sendOp(makeOp(lane, AW'(7), '0, 1'b1, AW'(7), ~DW'(d)));
			sendOp(makeOp(lane, '0, AW'(7), 1'b0, '0, '0));
		end

		for (int n = 0; n < RANDOM_OPS; n++) begin
			d = lcgNext(stimSeed);
			if (d[31:29] == 3'd0)
				idleCycle();  // Gap in the op stream
			sendOp(randomOp());
		end
		idleCycle();

		waitCycles = 0;
		while (pendingCount() != 0 && waitCycles < DRAIN_WAIT) begin
			@(posedge iClkX2);
			waitCycles++;
		end
		repeat (20) @(posedge iClkX2);  // Room for a stray duplicate

		if (pendingCount() != 0) begin
			abortRun($sformatf("%0d responses never reached the output", pendingCount()));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog/creditFifo.sv
// Credited FIFO
// Circular buffer for any payload type
// Pulses credit the cycle after each pop so the sender can refill
`timescale 1ns/1ps
`default_nettype none

module creditFifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 2
) (
	input  logic iClkX2,
	input  logic rstN,
	input  logic pushValid,
	input  T     pushData,
	input  logic pop,
	output logic popValid,
	output T     popData,
	output logic credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];  // Payload storage
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;

	assign popValid = (count != '0);
	assign popData  = mem[rdPtr];  // Head visible without a pop

	always_ff @(posedge iClkX2) begin
		if (!rstN) begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (pushValid)
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count  <= count + CNT_W'(pushValid) - CNT_W'(pop);
			credit <= pop;  // One credit per freed entry
		end
	end

	always_ff @(posedge iClkX2) begin
		if (pushValid)
			mem[wrPtr] <= pushData;
	end

	// Sender overrun means a lost credit somewhere upstream
	assert property (@(posedge iClkX2) disable iff (!rstN) pushValid |-> count != CNT_W'(DEPTH));
	assert property (@(posedge iClkX2) disable iff (!rstN) pop |-> popValid);

endmodule

`default_nettype wire

//--- verilog/dualPortRam.sv
// Dual-port synchronous RAM
// Port A reads or writes, port B reads only
// Both outputs register one cycle after an enabled access
`timescale 1ns/1ps
`default_nettype none

module dualPortRam #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 5
) (
	input  logic                  iClkX2,
	input  logic                  enA,
	input  logic                  weA,
	input  logic [ADDR_WIDTH-1:0] addrA,
	input  logic [DATA_WIDTH-1:0] dataInA,
	input  logic                  enB,
	input  logic [ADDR_WIDTH-1:0] addrB,
	output logic [DATA_WIDTH-1:0] dataOutA,
	output logic [DATA_WIDTH-1:0] dataOutB
);

	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];  // Block RAM array

	// Port A, read-first on a write
	always_ff @(posedge iClkX2) begin
		if (enA) begin
			if (weA)
				mem[addrA] <= dataInA;
			dataOutA <= mem[addrA];
		end
	end

	// Port B read only
	always_ff @(posedge iClkX2) begin
		if (enB)
			dataOutB <= mem[addrB];
	end

endmodule

`default_nettype wire

//--- verilog/opDispatcher.sv
// Op dispatcher
// Input queue with one credit counter per lane
// Head op leaves when its lane has a credit, else the queue blocks
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module opDispatcher (
	input  logic                                    iClkX2,
	input  logic                                    rstN,
	input  logic                                    opValid,
	input  regFetchPkg::regOpT                      opIn,
	input  logic [`NUM_LANES-1:0]                   laneOpCredit,
	output logic                                    opCredit,
	output logic [`NUM_LANES-1:0]                   laneOpValid,
	output regFetchPkg::regOpT [`NUM_LANES-1:0]     laneOp
);

	import regFetchPkg::*;

	localparam int CW = $clog2(`LANE_DEPTH + 1);

	regOpT                 head;
	regOpT                 opQ;          // Op on its way to a lane
	logic                  headValid;
	logic                  fire;
	logic [`NUM_LANES-1:0] laneHasCredit;

	creditFifo #(
		.T    (regOpT),
		.DEPTH(`IN_DEPTH)
	) uInQueue (
		.iClkX2   (iClkX2),
		.rstN     (rstN),
		.pushValid(opValid),
		.pushData (opIn),
		.pop      (fire),
		.popValid (headValid),
		.popData  (head),
		.credit   (opCredit)
	);

	assign fire = headValid && laneHasCredit[head.lane];  // In-order, head blocks

	for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
		logic [CW-1:0] cnt;
		logic          take;

		assign take             = fire && (head.lane == laneIdxT'(i));
		assign laneHasCredit[i] = (cnt != '0);
		assign laneOp[i]        = opQ;  // Payload broadcast, valid is one-hot

		always_ff @(posedge iClkX2) begin
			if (!rstN)
				cnt <= CW'(`LANE_DEPTH);
			else
				cnt <= cnt - CW'(take) + CW'(laneOpCredit[i]);
		end

		// Lane returned more credits than it has slots
		assert property (@(posedge iClkX2) disable iff (!rstN) cnt <= CW'(`LANE_DEPTH));
	end

	// Registered output one cycle after the pop
	always_ff @(posedge iClkX2) begin
		if (!rstN)
			laneOpValid <= '0;
		else
			laneOpValid <= fire ? (`NUM_LANES'(1) << head.lane) : '0;
	end

	always_ff @(posedge iClkX2) begin
		if (fire)
			opQ <= head;
	end

endmodule

`default_nettype wire

//--- verilog/regFetchPkg.sv
// Register fetch types
// Op and response payloads carried across every credited hop
`default_nettype none

`include "regFetch_config.svh"

package regFetchPkg;

	// Lane number
	typedef logic [$clog2(`NUM_LANES)-1:0] laneIdxT;

	// Register op from upstream
	typedef struct packed {
		logic [`TAG_WIDTH-1:0]  tag;     // Returned with the response
		laneIdxT                lane;    // Destination thread
		logic [`ADDR_WIDTH-1:0] rs0;     // First read address
		logic [`ADDR_WIDTH-1:0] rs1;     // Second read address
		logic                   rdWrEn;  // Optional write
		logic [`ADDR_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0] rdData;
	} regOpT;

	// Read response toward downstream
	typedef struct packed {
		logic [`TAG_WIDTH-1:0]  tag;
		laneIdxT                lane;
		logic [`DATA_WIDTH-1:0] rs0Data;  // Value before the op's own write
		logic [`DATA_WIDTH-1:0] rs1Data;
	} regRespT;

endpackage

`default_nettype wire

//--- verilog/regFetchTop.sv
// Register fetch stage
// Dispatcher, one register lane per thread and the response collector
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module regFetchTop (
	input  logic                 iClkX2,
	input  logic                 rstN,
	input  logic                 opValid,
	input  regFetchPkg::regOpT   opIn,
	input  logic                 outCredit,
	output logic                 opCredit,
	output logic                 outValid,
	output regFetchPkg::regRespT outResp
);

	import regFetchPkg::*;

	// Dispatcher to lanes
	logic [`NUM_LANES-1:0]           laneOpValid;
	regOpT [`NUM_LANES-1:0]          laneOp;
	logic [`NUM_LANES-1:0]           laneOpCredit;

	// Lanes to collector
	logic [`NUM_LANES-1:0]           respValid;
	regRespT [`NUM_LANES-1:0]        resp;
	logic [`NUM_LANES-1:0]           respCredit;

	opDispatcher uDispatcher (
		.iClkX2      (iClkX2),
		.rstN        (rstN),
		.opValid     (opValid),
		.opIn        (opIn),
		.laneOpCredit(laneOpCredit),
		.opCredit    (opCredit),
		.laneOpValid (laneOpValid),
		.laneOp      (laneOp)
	);

	for (genvar i = 0; i < `NUM_LANES; i++) begin : gLane
		regLane uLane (
			.iClkX2    (iClkX2),
			.rstN      (rstN),
			.opValid   (laneOpValid[i]),
			.op        (laneOp[i]),
			.respCredit(respCredit[i]),
			.opCredit  (laneOpCredit[i]),
			.respValid (respValid[i]),
			.resp      (resp[i])
		);
	end

	respCollector uCollector (
		.iClkX2    (iClkX2),
		.rstN      (rstN),
		.respValid (respValid),
		.resp      (resp),
		.outCredit (outCredit),
		.respCredit(respCredit),
		.outValid  (outValid),
		.outResp   (outResp)
	);

endmodule

`default_nettype wire

//--- verilog/regFetch_config.svh
// Register fetch configuration
// Lane count, datapath widths and queue depths shared by every block
`ifndef REGFETCH_CONFIG_SVH
`define REGFETCH_CONFIG_SVH

`define NUM_LANES   4   // Hardware threads
`define DATA_WIDTH  32  // Register width
`define ADDR_WIDTH  5   // 32 registers per lane
`define TAG_WIDTH   8   // Op tag

// Queue depths, also the initial credit count of each sender
`define IN_DEPTH    4   // Dispatcher input queue
`define LANE_DEPTH  2   // Per-lane op queue
`define RESP_DEPTH  2   // Per-lane response queue in the collector

// Credits held toward downstream after reset
`define OUT_CREDITS 4

`endif

//--- verilog/regLane.sv
// One hardware thread
// Op queue feeding the lane's register file
// Pops only with a response credit and in the read slot
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module regLane (
	input  logic                iClkX2,
	input  logic                rstN,
	input  logic                opValid,
	input  regFetchPkg::regOpT  op,
	input  logic                respCredit,
	output logic                opCredit,
	output logic                respValid,
	output regFetchPkg::regRespT resp
);

	import regFetchPkg::*;

	localparam int CW = $clog2(`RESP_DEPTH + 1);

	regOpT                  head;
	logic                   headValid;
	logic                   issue;
	logic                   rfReady;
	logic                   rfValid;
	logic [`DATA_WIDTH-1:0] rs0Data;
	logic [`DATA_WIDTH-1:0] rs1Data;
	logic [CW-1:0]          respCnt;   // Free slots in the collector queue
	logic [`TAG_WIDTH-1:0]  tagQ;      // Tag of the op in the register file
	laneIdxT                laneQ;

	creditFifo #(
		.T    (regOpT),
		.DEPTH(`LANE_DEPTH)
	) uOpQueue (
		.iClkX2   (iClkX2),
		.rstN     (rstN),
		.pushValid(opValid),
		.pushData (op),
		.pop      (issue),
		.popValid (headValid),
		.popData  (head),
		.credit   (opCredit)
	);

	// At most every other cycle, set by the read slot
	assign issue = headValid && rfReady && (respCnt != '0);

	registerFile uRegFile (
		.iClkX2  (iClkX2),
		.rstN    (rstN),
		.reqValid(issue),
		.req     (head),
		.reqReady(rfReady),
		.rdValid (rfValid),
		.rs0Data (rs0Data),
		.rs1Data (rs1Data)
	);

	always_ff @(posedge iClkX2) begin
		if (!rstN) begin
			respCnt   <= CW'(`RESP_DEPTH);
			respValid <= 1'b0;
		end else begin
			respCnt   <= respCnt - CW'(issue) + CW'(respCredit);  // Spent at issue
			respValid <= rfValid;
		end
	end

	// Tag rides alongside the reads, next issue is two cycles away
	always_ff @(posedge iClkX2) begin
		if (issue) begin
			tagQ  <= head.tag;
			laneQ <= head.lane;
		end
		if (rfValid)
			resp <= '{tag: tagQ, lane: laneQ, rs0Data: rs0Data, rs1Data: rs1Data};
	end

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
// Two-read one-write register file for one lane
// One dual-port RAM at iClkX2 with an internal phase flop
// Read slot reads rs0 on port A and rs1 on port B
// Write slot writes rd on port A, register 0 stays zero
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module registerFile (
	input  logic                   iClkX2,
	input  logic                   rstN,
	input  logic                   reqValid,
	input  regFetchPkg::regOpT     req,
	output logic                   reqReady,
	output logic                   rdValid,
	output logic [`DATA_WIDTH-1:0] rs0Data,
	output logic [`DATA_WIDTH-1:0] rs1Data
);

	logic                   wrSlot;    // Low in the read slot
	logic                   accept;
	logic                   wrPend;    // Write due in this write slot
	logic                   readPend;  // RAM outputs hold this op's reads
	logic [`ADDR_WIDTH-1:0] rs0Q;
	logic [`ADDR_WIDTH-1:0] rs1Q;
	logic [`ADDR_WIDTH-1:0] rdQ;
	logic [`DATA_WIDTH-1:0] rdDataQ;

	// RAM port signals
	logic                   ramEnA;
	logic                   ramWeA;
	logic [`ADDR_WIDTH-1:0] ramAddrA;
	logic [`DATA_WIDTH-1:0] ramOutA;
	logic [`DATA_WIDTH-1:0] ramOutB;

	assign reqReady = !wrSlot;  // Requests only in the read slot
	assign accept   = reqValid && reqReady;

	// Port A shared between rs0 read and rd write
	assign ramEnA   = wrSlot ? wrPend : accept;
	assign ramWeA   = wrSlot && wrPend && (rdQ != '0);  // Writes to r0 dropped
	assign ramAddrA = wrSlot ? rdQ : req.rs0;

	dualPortRam #(
		.DATA_WIDTH(`DATA_WIDTH),
		.ADDR_WIDTH(`ADDR_WIDTH)
	) uRam (
		.iClkX2  (iClkX2),
		.enA     (ramEnA),
		.weA     (ramWeA),
		.addrA   (ramAddrA),
		.dataInA (rdDataQ),
		.enB     (accept),
		.addrB   (req.rs1),
		.dataOutA(ramOutA),
		.dataOutB(ramOutB)
	);

	// Phase and pipeline control
	always_ff @(posedge iClkX2) begin
		if (!rstN) begin
			wrSlot   <= 1'b0;
			wrPend   <= 1'b0;
			readPend <= 1'b0;
			rdValid  <= 1'b0;
		end else begin
			wrSlot   <= !wrSlot;
			wrPend   <= accept && req.rdWrEn;
			readPend <= accept;
			rdValid  <= readPend;  // Two cycles after acceptance
		end
	end

	// Addresses and write payload of the accepted op
	always_ff @(posedge iClkX2) begin
		if (accept) begin
			rs0Q    <= req.rs0;
			rs1Q    <= req.rs1;
			rdQ     <= req.rd;
			rdDataQ <= req.rdData;
		end
	end

	// Hold reads before port A output is overwritten by the write
	always_ff @(posedge iClkX2) begin
		if (readPend) begin
			rs0Data <= (rs0Q == '0) ? '0 : ramOutA;
			rs1Data <= (rs1Q == '0) ? '0 : ramOutB;
		end
	end

	// Lane queue must respect the read slot
	assert property (@(posedge iClkX2) disable iff (!rstN) reqValid |-> reqReady);

endmodule

`default_nettype wire

//--- verilog/respCollector.sv
// Response collector
// One response queue per lane, merged round-robin onto the output
// Output is credited by downstream
`timescale 1ns/1ps
`default_nettype none

`include "regFetch_config.svh"

module respCollector (
	input  logic                                  iClkX2,
	input  logic                                  rstN,
	input  logic [`NUM_LANES-1:0]                 respValid,
	input  regFetchPkg::regRespT [`NUM_LANES-1:0] resp,
	input  logic                                  outCredit,
	output logic [`NUM_LANES-1:0]                 respCredit,
	output logic                                  outValid,
	output regFetchPkg::regRespT                  outResp
);

	import regFetchPkg::*;

	localparam int CW = $clog2(`OUT_CREDITS + 1);

	regRespT               headResp [`NUM_LANES];
	logic [`NUM_LANES-1:0] notEmpty;
	logic [`NUM_LANES-1:0] pop;
	laneIdxT               rrPtr;     // Lane with first pick
	laneIdxT               sel;
	logic                  found;
	logic                  fire;
	logic [CW-1:0]         outCnt;

	for (genvar i = 0; i < `NUM_LANES; i++) begin : gQueue
		assign pop[i] = fire && (sel == laneIdxT'(i));

		creditFifo #(
			.T    (regRespT),
			.DEPTH(`RESP_DEPTH)
		) uRespQueue (
			.iClkX2   (iClkX2),
			.rstN     (rstN),
			.pushValid(respValid[i]),
			.pushData (resp[i]),
			.pop      (pop[i]),
			.popValid (notEmpty[i]),
			.popData  (headResp[i]),
			.credit   (respCredit[i])
		);
	end

	// First non-empty queue at or after rrPtr
	always_comb begin
		found = 1'b0;
		sel   = rrPtr;
		for (int k = 0; k < `NUM_LANES; k++) begin
			if (!found && notEmpty[(int'(rrPtr) + k) % `NUM_LANES]) begin
				found = 1'b1;
				sel   = laneIdxT'((int'(rrPtr) + k) % `NUM_LANES);
			end
		end
	end

	assign fire = found && (outCnt != '0);

	always_ff @(posedge iClkX2) begin
		if (!rstN) begin
			rrPtr    <= '0;
			outCnt   <= CW'(`OUT_CREDITS);
			outValid <= 1'b0;
		end else begin
			if (fire)
				rrPtr <= (sel == laneIdxT'(`NUM_LANES - 1)) ? '0 : sel + 1'b1;  // Past the winner
			outCnt   <= outCnt - CW'(fire) + CW'(outCredit);
			outValid <= fire;
		end
	end

	always_ff @(posedge iClkX2) begin
		if (fire)
			outResp <= headResp[sel];
	end

	// Downstream returned more credits than it granted
	assert property (@(posedge iClkX2) disable iff (!rstN) outCnt <= CW'(`OUT_CREDITS));

endmodule

`default_nettype wire
